// ==== fused_defines.svh ====
`ifndef FUSED_DEFINES_SVH
`define FUSED_DEFINES_SVH

// Data widths
`define ACT_W            8
`define LANES            4
`define WORD_W           (`LANES * `ACT_W)
`define ACC_W            20

// Layer-2 shape, fixed at build time
`define CHANNELS         16
`define FILTERS          4
`define WORDS_PER_PIXEL  (`CHANNELS / `LANES)
`define BUF_PIXELS       4

// Fixed point
`define RELU6_CEIL       96    // 6.0 in Q4.4
`define ACC_SHIFT        4     // Q8.8 sum back to Q4.4

// Stream timing
`define PIXEL_GAP        4     // Min cycles between pixel strobes
`define PIPE_LATENCY     11    // pixel_valid to out_valid

`endif

// ==== fused_pkg.sv ====
`include "fused_defines.svh"

package fused_pkg;

    typedef logic        [`ACT_W-1:0]  act_t;     // Q4.4 activation
    typedef logic signed [`ACT_W-1:0]  weight_t;  // Signed Q4.4 weight
    typedef logic        [`WORD_W-1:0] word_t;    // Four lanes
    typedef logic signed [`ACC_W-1:0]  acc_t;

    typedef logic [1:0] word_idx_t;               // Word within a pixel
    typedef logic [3:0] buf_addr_t;               // {slot, word}
    typedef logic [1:0] filter_idx_t;

    typedef struct packed {
        act_t [`CHANNELS-1:0] ch;                 // Channel 0 in low byte
    } pixel_t;

    typedef struct packed {
        logic [`FILTERS-1:0][`ACT_W-1:0] f;       // Filter 0 in low byte
    } result_t;

    typedef struct packed {
        filter_idx_t filter;
        word_idx_t   word;
        word_t       data;
    } weight_wr_t;

    typedef struct packed {
        word_t [`FILTERS-1:0] w;                  // One word per filter
    } weight_set_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,                                     // Words 0..2
        FINISH                                    // Last word, pixel consumed
    } pw_state_t;

endpackage

// ==== relu6_stage.sv ====
`include "fused_defines.svh"

module relu6_stage import fused_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   pixel_valid,
    input  pixel_t pixel,
    output logic   act_valid,
    output pixel_t act_pixel
);

    pixel_t clamped;

    always_comb begin
        for (int c = 0; c < `CHANNELS; c++) begin
            if ($signed(pixel.ch[c]) < 0)
                clamped.ch[c] = '0;                          // Negative to zero
            else if ($signed(pixel.ch[c]) > `RELU6_CEIL)
                clamped.ch[c] = act_t'(`RELU6_CEIL);         // Clip at 6.0
            else
                clamped.ch[c] = pixel.ch[c];
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            act_valid <= 1'b0;
        else
            act_valid <= pixel_valid;
    end

    always_ff @(posedge clk) begin
        if (pixel_valid)
            act_pixel <= clamped;
    end

    // Upstream must respect the minimum pixel spacing
    a_pixel_gap: assert property (@(posedge clk) disable iff (reset)
        pixel_valid |=> !pixel_valid [*(`PIXEL_GAP-1)]);

endmodule

// ==== act_buffer.sv ====
`include "fused_defines.svh"

module act_buffer import fused_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      act_valid,
    input  pixel_t    act_pixel,
    input  buf_addr_t rd_addr,
    output word_t     rd_data,
    output logic      pixel_ready
);

    pixel_t                          wr_pixel;
    logic                            wr_busy;
    word_idx_t                       wr_idx;
    logic [$clog2(`BUF_PIXELS)-1:0]  wr_slot;
    word_t                           wr_word;
    logic                            last_word;
    word_t                           ram [`BUF_PIXELS*`WORDS_PER_PIXEL];

    assign last_word   = wr_busy && (wr_idx == word_idx_t'(`WORDS_PER_PIXEL-1));
    assign pixel_ready = last_word;                          // Pixel fully stored

    // Lane mux picks four channels for the current word
    always_comb begin
        for (int l = 0; l < `LANES; l++) begin
            wr_word[l*`ACT_W +: `ACT_W] = wr_pixel.ch[wr_idx*`LANES + l];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_busy <= 1'b0;
            wr_idx  <= '0;
            wr_slot <= '0;
        end else begin
            if (last_word)
                wr_slot <= wr_slot + 1'b1;                   // Next slot, wraps
            if (act_valid) begin
                wr_busy <= 1'b1;                             // New pixel may follow back to back
                wr_idx  <= '0;
            end else if (last_word) begin
                wr_busy <= 1'b0;
            end else if (wr_busy) begin
                wr_idx <= wr_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (act_valid)
            wr_pixel <= act_pixel;
    end

    always_ff @(posedge clk) begin
        if (wr_busy)
            ram[{wr_slot, wr_idx}] <= wr_word;
        rd_data <= ram[rd_addr];                             // Registered read
    end

    // A new pixel may only land in the last write cycle or later
    a_no_overrun: assert property (@(posedge clk) disable iff (reset)
        act_valid |-> (!wr_busy || last_word));

endmodule

// ==== weight_bank.sv ====
`include "fused_defines.svh"

module weight_bank import fused_pkg::*; (
    input  logic        clk,
    input  logic        weight_we,
    input  weight_wr_t  weight_wr,
    input  word_idx_t   rd_word,
    output weight_set_t weights
);

    word_t mem [`FILTERS][`WORDS_PER_PIXEL];                 // One array per filter

    always_ff @(posedge clk) begin
        if (weight_we)
            mem[weight_wr.filter][weight_wr.word] <= weight_wr.data;
    end

    // Same word index from every filter
    always_ff @(posedge clk) begin
        for (int f = 0; f < `FILTERS; f++) begin
            weights.w[f] <= mem[f][rd_word];
        end
    end

endmodule

// ==== pointwise_controller.sv ====
`include "fused_defines.svh"

module pointwise_controller import fused_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      pixel_ready,
    output buf_addr_t rd_addr,
    output word_idx_t rd_word,
    output logic      pe_clear,
    output logic      pe_acc,
    output logic      pe_finish
);

    pw_state_t                          state;
    pw_state_t                          state_next;
    word_idx_t                          word_cnt;
    logic [$clog2(`BUF_PIXELS)-1:0]     rd_slot;
    logic [$clog2(`BUF_PIXELS+1)-1:0]   pending;             // Stored, not yet read

    assign rd_addr = {rd_slot, word_cnt};
    assign rd_word = word_cnt;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (pixel_ready || pending != '0)
                    state_next = READ;
            end
            READ: begin
                if (word_cnt == word_idx_t'(`WORDS_PER_PIXEL-2))
                    state_next = FINISH;
            end
            FINISH: begin
                // Chain straight into the next pixel if one is waiting
                state_next = (pixel_ready || pending > 1) ? READ : IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            word_cnt  <= '0;
            rd_slot   <= '0;
            pending   <= '0;
            pe_clear  <= 1'b0;
            pe_acc    <= 1'b0;
            pe_finish <= 1'b0;
        end else begin
            state <= state_next;
            if (state == READ)
                word_cnt <= word_cnt + 1'b1;
            else
                word_cnt <= '0;
            if (state == FINISH)
                rd_slot <= rd_slot + 1'b1;
            case ({pixel_ready, state == FINISH})
                2'b10:   pending <= pending + 1'b1;
                2'b01:   pending <= pending - 1'b1;
                default: pending <= pending;
            endcase
            // One cycle later, in line with the RAM read data
            pe_clear  <= (state == READ) && (word_cnt == '0);
            pe_acc    <= (state != IDLE);
            pe_finish <= (state == FINISH);
        end
    end

    a_pending_bound: assert property (@(posedge clk) disable iff (reset)
        pending <= `BUF_PIXELS);

endmodule

// ==== pe_cluster_1x1.sv ====
`include "fused_defines.svh"

module pe_cluster_1x1 import fused_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  word_t       rd_data,
    input  weight_set_t weights,
    input  logic        pe_clear,
    input  logic        pe_acc,
    input  logic        pe_finish,
    output logic        out_valid,
    output result_t     result
);

    acc_t acc      [`FILTERS];
    acc_t acc_next [`FILTERS];

    // Four lane products of one word, summed
    function automatic acc_t lane_sum(word_t act_word, word_t wt_word);
        acc_t    sum;
        acc_t    prod;
        act_t    a;
        weight_t w;
        sum = '0;
        for (int l = 0; l < `LANES; l++) begin
            a    = act_word[l*`ACT_W +: `ACT_W];
            w    = wt_word[l*`ACT_W +: `ACT_W];
            prod = $signed({1'b0, a}) * w;                   // Activation is non-negative
            sum  = sum + prod;
        end
        return sum;
    endfunction

    function automatic logic [`ACT_W-1:0] saturate(acc_t sum);
        acc_t shifted;
        shifted = sum >>> `ACC_SHIFT;
        if (shifted < 0)
            return '0;
        else if (shifted > 255)
            return '1;
        else
            return shifted[`ACT_W-1:0];
    endfunction

    always_comb begin
        for (int f = 0; f < `FILTERS; f++) begin
            acc_next[f] = (pe_clear ? acc_t'(0) : acc[f]) + lane_sum(rd_data, weights.w[f]);
        end
    end

    always_ff @(posedge clk) begin
        for (int f = 0; f < `FILTERS; f++) begin
            if (pe_acc)
                acc[f] <= acc_next[f];
            if (pe_finish)
                result.f[f] <= saturate(acc_next[f]);        // Includes the last word
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            out_valid <= 1'b0;
        else
            out_valid <= pe_finish;
    end

endmodule

// ==== fused_pointwise_top.sv ====
module fused_pointwise_top import fused_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       pixel_valid,
    input  pixel_t     pixel,
    input  logic       weight_we,
    input  weight_wr_t weight_wr,
    output logic       out_valid,
    output result_t    result
);

    logic        act_valid;
    pixel_t      act_pixel;
    logic        pixel_ready;
    buf_addr_t   rd_addr;
    word_idx_t   rd_word;
    word_t       rd_data;
    weight_set_t weights;
    logic        pe_clear;
    logic        pe_acc;
    logic        pe_finish;

    relu6_stage relu6_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .act_valid   (act_valid),
        .act_pixel   (act_pixel)
    );

    act_buffer act_buffer_inst (
        .clk         (clk),
        .reset       (reset),
        .act_valid   (act_valid),
        .act_pixel   (act_pixel),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .pixel_ready (pixel_ready)
    );

    weight_bank weight_bank_inst (
        .clk         (clk),
        .weight_we   (weight_we),
        .weight_wr   (weight_wr),
        .rd_word     (rd_word),
        .weights     (weights)
    );

    pointwise_controller pointwise_controller_inst (
        .clk         (clk),
        .reset       (reset),
        .pixel_ready (pixel_ready),
        .rd_addr     (rd_addr),
        .rd_word     (rd_word),
        .pe_clear    (pe_clear),
        .pe_acc      (pe_acc),
        .pe_finish   (pe_finish)
    );

    pe_cluster_1x1 pe_cluster_1x1_inst (
        .clk         (clk),
        .reset       (reset),
        .rd_data     (rd_data),
        .weights     (weights),
        .pe_clear    (pe_clear),
        .pe_acc      (pe_acc),
        .pe_finish   (pe_finish),
        .out_valid   (out_valid),
        .result      (result)
    );

endmodule

// ==== tb_fused_pointwise.sv ====
`include "fused_defines.svh"

module tb_fused_pointwise import fused_pkg::*; ();

    localparam int RESET_CYCLES    = 16;
    localparam int STREAM_PIXELS   = 200;
    localparam int TOTAL_PIXELS    = 1 + 4 + 2 + STREAM_PIXELS + 8;
    localparam int MARGIN_CYCLES   = 600;                   // Weight loads, drains, idle gaps
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_PIXELS * `PIXEL_GAP
                                     + `PIPE_LATENCY + MARGIN_CYCLES;

    logic       clk;
    logic       reset;
    logic       pixel_valid;
    pixel_t     pixel;
    logic       weight_we;
    weight_wr_t weight_wr;
    logic       out_valid;
    result_t    result;

    integer  seed = 16474;
    int      cycle = 0;
    int      errors = 0;
    int      checks = 0;
    int      tests_run = 0;
    int      tests_failed = 0;
    int      errors_at_start = 0;
    int      out_count = 0;
    result_t last_result;
    result_t exp_q [$];                                     // Model results in send order
    int      sent_q [$];                                    // Cycle of each pixel strobe
    weight_t model_w [`FILTERS][`CHANNELS];
    pixel_t  saved [4];

    fused_pointwise_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .weight_we   (weight_we),
        .weight_wr   (weight_wr),
        .out_valid   (out_valid),
        .result      (result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_result(input string name, input result_t actual, input result_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_valid_count(input string name, input int actual, input int expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_latency(input int actual);
        checks++;
        if (actual !== `PIPE_LATENCY) begin
            errors++;
            $display("MISMATCH out_valid latency: expected %0h, actual %0h",
                     `PIPE_LATENCY, actual);
        end
    endtask

    function automatic int relu6_model(logic [7:0] x);
        int v;
        v = $signed(x);
        if (v < 0)
            return 0;
        if (v > `RELU6_CEIL)
            return `RELU6_CEIL;
        return v;
    endfunction

    // Sum of clamped channel times signed weight scaled back to a byte
    function automatic result_t expected_result(pixel_t p);
        result_t r;
        int      sum;
        int      shifted;
        for (int f = 0; f < `FILTERS; f++) begin
            sum = 0;
            for (int c = 0; c < `CHANNELS; c++)
                sum += relu6_model(p.ch[c]) * int'(model_w[f][c]);
            shifted = sum >>> `ACC_SHIFT;
            r.f[f] = (shifted < 0) ? 8'd0 : (shifted > 255) ? 8'd255 : shifted[7:0];
        end
        return r;
    endfunction

    function automatic pixel_t random_pixel();
        pixel_t p;
        for (int c = 0; c < `CHANNELS; c++)
            p.ch[c] = act_t'($random(seed));                // Full signed byte range
        return p;
    endfunction

    function automatic weight_t basic_weight(int f, int c);
        case (f)
            0:       return 8'sd4;                          // 0.25
            1:       return (c % 2 == 0) ? 8'sd8 : -8'sd4;
            2:       return weight_t'(c - 8);
            default: return (c < 4) ? 8'sd32 : 8'sd0;
        endcase
    endfunction

    task automatic fill_weights(input weight_t v);
        for (int f = 0; f < `FILTERS; f++)
            for (int c = 0; c < `CHANNELS; c++)
                model_w[f][c] = v;
    endtask

    task automatic randomize_weights();
        for (int f = 0; f < `FILTERS; f++)
            for (int c = 0; c < `CHANNELS; c++)
                model_w[f][c] = weight_t'($random(seed));
    endtask

    // Lane l of word w holds channel w*LANES+l
    task automatic write_weights();
        for (int f = 0; f < `FILTERS; f++) begin
            for (int w = 0; w < `WORDS_PER_PIXEL; w++) begin
                @(negedge clk);
                weight_we        = 1'b1;
                weight_wr.filter = filter_idx_t'(f);
                weight_wr.word   = word_idx_t'(w);
                for (int l = 0; l < `LANES; l++)
                    weight_wr.data[l*`ACT_W +: `ACT_W] = model_w[f][w*`LANES + l];
            end
        end
        @(negedge clk);
        weight_we = 1'b0;
    endtask

    task automatic send_pixel(input pixel_t p);
        @(negedge clk);
        pixel_valid = 1'b1;
        pixel       = p;
        exp_q.push_back(expected_result(p));
        sent_q.push_back(cycle);
        @(negedge clk);
        pixel_valid = 1'b0;
        repeat (`PIXEL_GAP - 2) @(negedge clk);             // Next strobe lands PIXEL_GAP later
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 4 * `PIPE_LATENCY) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("ERROR: %0d expected results never came out", exp_q.size());
            exp_q.delete();
            sent_q.delete();
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic begin_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %-14s PASS", name);
        end else begin
            tests_failed++;
            $display("test %-14s FAIL, %0d errors", name, errors - errors_at_start);
        end
    endtask

    always @(negedge clk) begin
        if (!reset && out_valid === 1'b1) begin
            out_count++;
            last_result = result;
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR: out_valid pulsed with no pixel outstanding, cycle %0d", cycle);
            end else begin
                check_result("result", result, exp_q.pop_front());
                check_latency(cycle - sent_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        pixel_t p;
        int     base;
        reset       = 1'b1;
        pixel_valid = 1'b0;
        pixel       = '0;
        weight_we   = 1'b0;
        weight_wr   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        begin_test();
        repeat (20) @(negedge clk);
        check_valid_count("out_valid pulses", out_count, 0);
        end_test("idle");

        begin_test();
        for (int f = 0; f < `FILTERS; f++)
            for (int c = 0; c < `CHANNELS; c++)
                model_w[f][c] = basic_weight(f, c);
        write_weights();
        for (int c = 0; c < `CHANNELS; c++)
            p.ch[c] = act_t'(c * 6);                        // 0 .. 5.625
        send_pixel(p);
        wait_drain();
        check_valid_count("out_valid pulses", out_count, 1);
        end_test("basic");

        begin_test();
        for (int c = 0; c < `CHANNELS; c++)
            p.ch[c] = (c % 2 == 0) ? 8'h7f : 8'h80;
        send_pixel(p);
        for (int c = 0; c < `CHANNELS; c++) begin
            case (c % 4)
                0:       p.ch[c] = 8'hff;                   // -1
                1:       p.ch[c] = 8'd97;                   // Just above 6.0
                2:       p.ch[c] = 8'd96;
                default: p.ch[c] = 8'h00;
            endcase
        end
        send_pixel(p);
        repeat (2) send_pixel(random_pixel());
        wait_drain();
        check_valid_count("out_valid pulses", out_count, 5);
        end_test("relu6_clip");

        begin_test();
        fill_weights(8'sd127);
        write_weights();
        for (int c = 0; c < `CHANNELS; c++)
            p.ch[c] = 8'd96;
        send_pixel(p);
        wait_drain();
        check_result("result", last_result, result_t'({`FILTERS{8'hff}}));
        fill_weights(-8'sd128);
        write_weights();
        send_pixel(p);
        wait_drain();
        check_result("result", last_result, result_t'({`FILTERS{8'h00}}));
        check_valid_count("out_valid pulses", out_count, 7);
        end_test("saturation");

        begin_test();
        randomize_weights();
        write_weights();
        base = out_count;
        for (int i = 0; i < STREAM_PIXELS; i++)
            send_pixel(random_pixel());
        wait_drain();
        check_valid_count("out_valid pulses", out_count - base, STREAM_PIXELS);
        end_test("throughput");

        begin_test();
        base = out_count;
        for (int i = 0; i < 4; i++) begin
            saved[i] = random_pixel();
            send_pixel(saved[i]);
        end
        wait_drain();
        randomize_weights();
        write_weights();
        for (int i = 0; i < 4; i++)
            send_pixel(saved[i]);                           // Same pixels with new weights
        wait_drain();
        check_valid_count("out_valid pulses", out_count - base, 8);
        end_test("weight_rewrite");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+.
fused_pkg.sv
relu6_stage.sv
act_buffer.sv
weight_bank.sv
pointwise_controller.sv
pe_cluster_1x1.sv
fused_pointwise_top.sv
tb_fused_pointwise.sv

// ==== Makefile ====
TOP = tb_fused_pointwise

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
